/* vlog.f */
logic/rst_src_pkg.sv
logic/rst_domain_pkg.sv
logic/rst_domain_if.sv
logic/rst_source_sync.sv
logic/rst_domain_stretch.sv
logic/rst_flag_unit.sv
logic/rcc_rst_top.sv
bench/rcc_rst_checker.sv
bench/tb_rcc_rst.sv

/* Makefile */
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module tb_rcc_rst -f vlog.f -o sim

run: build
	./obj_dir/sim | tee $(LOG)
	grep -q "^Done: no errors$$" $(LOG)

lint:
	verilator --lint-only -Wall --timing --top-module rcc_rst_top -f vlog.f

clean:
	rm -rf obj_dir $(LOG)

/* bench/tb_rcc_rst.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rcc_rst;

    import rst_src_pkg::*;
    import rst_domain_pkg::*;

    localparam int unsigned SEED = 32'h51a5ec73;

    // sources hitting every domain, the core-only pair, the pin pullers
    localparam src_vec_t ALL_SRC  = src_vec_t'((1 << SRC_PIN) | (1 << SRC_POR_BOR)
                                               | (1 << SRC_IWDG));
    localparam src_vec_t CORE_SRC = src_vec_t'((1 << SRC_WWDG) | (1 << SRC_CPU_SW));
    localparam src_vec_t PULL_SRC = src_vec_t'(1 << SRC_IWDG) | CORE_SRC;
    localparam src_vec_t POR_ONLY = src_vec_t'(1 << SRC_POR_BOR);
    localparam dom_vec_t D1_BIT   = dom_vec_t'(1 << DOM_D1);
    localparam dom_vec_t D2_BIT   = dom_vec_t'(1 << DOM_D2);
    localparam dom_vec_t PX_BIT   = dom_vec_t'(1 << DOM_PERX);

    // expected state, one field per flop stage of the block
    typedef struct packed {
        src_vec_t                src_p0;
        src_vec_t                src_p1;
        dom_vec_t                pwr_p0;
        dom_vec_t                pwr_p1;
        dom_vec_t                req;
        dom_vec_t                pwr_ok;
        logic [NUM_DOM-1:0][4:0] run_len;
        dom_vec_t                rst_n;
        dom_vec_t                released;
        src_vec_t                flags;
        logic                    nrst;
    } model_t;

    logic     sys_d1cpre_clk;
    logic     pwr_d1_ok;
    src_vec_t rst_src;
    dom_vec_t dom_pwr_ok;
    logic     rmvf;
    dom_vec_t dom_rst_n;
    src_vec_t rst_flags;
    logic     nrst_out;
    model_t   mdl;
    int       checks   = 0;
    int       errors   = 0;
    int       timeouts = 0;

    rcc_rst_top u_rcc_rst_top (
        .sys_d1cpre_clk (sys_d1cpre_clk),
        .pwr_d1_ok      (pwr_d1_ok),
        .rst_src        (rst_src),
        .dom_pwr_ok     (dom_pwr_ok),
        .rmvf           (rmvf),
        .dom_rst_n      (dom_rst_n),
        .rst_flags      (rst_flags),
        .nrst_out       (nrst_out)
    );

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    // sources that reset a given domain
    function automatic src_vec_t dom_mask(input logic [1:0] d);
        if (d == 2'(DOM_D2)) begin
            return ALL_SRC | src_vec_t'(1 << SRC_LPWR);
        end
        return ALL_SRC | CORE_SRC;
    endfunction

    // release delay in cycles
    function automatic logic [4:0] dom_dur(input logic [1:0] d);
        return (d == 2'(DOM_PERX)) ? 5'd6 : 5'd10;
    endfunction

    // one rising edge of the block
    function automatic model_t model_step(input model_t m, input src_vec_t src,
                                          input dom_vec_t pwr, input logic clr);
        model_t n;
        logic   pull;
        n        = m;
        n.src_p0 = src;
        n.src_p1 = m.src_p0;
        n.pwr_p0 = pwr;
        n.pwr_p1 = m.pwr_p0;
        for (logic [1:0] d = 2'd0; d < 2'd3; d++) begin
            n.req[d]    = |(m.src_p1 & dom_mask(d));
            n.pwr_ok[d] = m.pwr_p1[d];
            // run of clean samples, any request or power loss restarts it
            if (m.req[d] || !m.pwr_ok[d]) begin
                n.run_len[d] = 5'd0;
            end else if (m.run_len[d] != 5'd31) begin
                n.run_len[d] = m.run_len[d] + 5'd1;
            end
            n.rst_n[d]    = (n.run_len[d] >= dom_dur(d));
            n.released[d] = (n.run_len[d] == dom_dur(d));
        end
        // set beats clear
        n.flags = (clr ? src_vec_t'(0) : m.flags) | m.src_p1;
        // pin low on d1 reset or a pulling source, high only after the d1 pulse
        pull = |(m.src_p1 & PULL_SRC);
        if (pull || !(|(m.rst_n & D1_BIT))) begin
            n.nrst = 1'b0;
        end else if (|(m.released & D1_BIT)) begin
            n.nrst = 1'b1;
        end
        return n;
    endfunction

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // edges counted from the last rising edge; an empty mask means nrst_out
    task automatic wait_level(input dom_vec_t which, input logic level, input int limit,
                              input string name, output int edges);
        logic now;
        edges = 0;
        now   = ~level;
        while (now !== level && edges < limit) begin
            @(posedge sys_d1cpre_clk);
            edges++;
            @(negedge sys_d1cpre_clk);
            now = (which == '0) ? nrst_out : |(dom_rst_n & which);
        end
        if (now !== level) begin
            timeouts++;
            $display("timeout: %s did not reach %0b within %0d cycles", name, level, limit);
        end
    endtask

    task automatic set_src(input src_vec_t bits, input logic val);
        @(posedge sys_d1cpre_clk);
        rst_src <= val ? (rst_src | bits) : (rst_src & ~bits);
    endtask

    task automatic set_pwr(input dom_vec_t bits, input logic val);
        @(posedge sys_d1cpre_clk);
        dom_pwr_ok <= val ? (dom_pwr_ok | bits) : (dom_pwr_ok & ~bits);
    endtask

    ////////////////////////////////////////
    // clock, model and compare
    ////////////////////////////////////////

    initial begin
        sys_d1cpre_clk = 1'b0;
        forever #20 sys_d1cpre_clk = ~sys_d1cpre_clk;
    end

    always @(posedge sys_d1cpre_clk or negedge pwr_d1_ok) begin
        if (!pwr_d1_ok) begin
            mdl       <= '0;
            mdl.flags <= POR_ONLY;
        end else begin
            mdl <= model_step(mdl, rst_src, dom_pwr_ok, rmvf);
        end
    end

    // outputs settle well before the falling edge
    always @(negedge sys_d1cpre_clk) begin
        check_value("dom_rst_n", 32'(dom_rst_n), 32'(mdl.rst_n));
        check_value("rst_flags", 32'(rst_flags), 32'(mdl.flags));
        check_value("nrst_out", 32'(nrst_out), 32'(mdl.nrst));
    end

    ////////////////////////////////////////
    // scenarios
    ////////////////////////////////////////

    initial begin
        int          n;
        int          m;
        src_vec_t    flags_before;
        logic [31:0] r;
        rst_src    = '0;
        dom_pwr_ok = '1;
        rmvf       = 1'b0;
        pwr_d1_ok  = 1'b0;
        void'($urandom(SEED));
        repeat (8) @(posedge sys_d1cpre_clk);
        pwr_d1_ok <= 1'b1;

        // 1. quiet release, perx first
        wait_level(PX_BIT, 1'b1, 20, "perx reset", n);
        check_value("perx release edges", n, 9);
        wait_level(D1_BIT, 1'b1, 20, "d1 reset", m);
        check_value("d1 release edges", n + m, 13);
        check_value("all domains out", 32'(dom_rst_n), 32'(D1_BIT | D2_BIT | PX_BIT));
        check_value("por flag", 32'(rst_flags & POR_ONLY), 32'(POR_ONLY));

        // 2. low-power pulse, d2 only
        set_src(src_vec_t'(1 << SRC_LPWR), 1'b1);
        wait_level(D2_BIT, 1'b0, 10, "d2 reset", n);
        check_value("d2 assert edges", n, 4);
        check_value("lpwr domains", 32'(dom_rst_n), 32'(D1_BIT | PX_BIT));
        check_value("lpwr flag", 32'(rst_flags[SRC_LPWR]), 32'd1);
        set_src(src_vec_t'(1 << SRC_LPWR), 1'b0);
        wait_level(D2_BIT, 1'b1, 20, "d2 reset", n);

        // 3. window watchdog pulls the pin until d1 is out
        set_src(src_vec_t'(1 << SRC_WWDG), 1'b1);
        wait_level('0, 1'b0, 10, "nrst_out", n);
        check_value("nrst_out fall edges", n, 3);
        wait_level(D1_BIT, 1'b0, 10, "d1 reset", n);
        check_value("wwdg domains", 32'(dom_rst_n), 32'(D2_BIT));
        set_src(src_vec_t'(1 << SRC_WWDG), 1'b0);
        wait_level(D1_BIT, 1'b1, 20, "d1 reset", n);
        check_value("nrst_out with d1 release", 32'(nrst_out), 32'd0);
        @(negedge sys_d1cpre_clk);
        check_value("nrst_out after d1 release", 32'(nrst_out), 32'd1);

        // 4. re-request in the middle of the d1 count
        set_src(src_vec_t'(1 << SRC_CPU_SW), 1'b1);
        wait_level(D1_BIT, 1'b0, 10, "d1 reset", n);
        set_src(src_vec_t'(1 << SRC_CPU_SW), 1'b0);
        repeat (6) @(posedge sys_d1cpre_clk);
        set_src(src_vec_t'(1 << SRC_CPU_SW), 1'b1);
        set_src(src_vec_t'(1 << SRC_CPU_SW), 1'b0);
        wait_level(D1_BIT, 1'b1, 30, "d1 reset", n);
        check_value("d1 restart edges", n, 13);

        // 5. d2 power drop, flags untouched
        flags_before = rst_flags;
        set_pwr(D2_BIT, 1'b0);
        wait_level(D2_BIT, 1'b0, 10, "d2 reset", n);
        check_value("d2 power drop edges", n, 4);
        check_value("power drop domains", 32'(dom_rst_n), 32'(D1_BIT | PX_BIT));
        set_pwr(D2_BIT, 1'b1);
        wait_level(D2_BIT, 1'b1, 20, "d2 reset", n);
        check_value("d2 power return edges", n, 13);
        check_value("flags after power drop", 32'(rst_flags), 32'(flags_before));

        // 6. clear while the pin source is still active
        set_src(src_vec_t'(1 << SRC_PIN), 1'b1);
        repeat (4) @(posedge sys_d1cpre_clk);
        @(posedge sys_d1cpre_clk);
        rmvf <= 1'b1;
        @(posedge sys_d1cpre_clk);
        rmvf <= 1'b0;
        @(negedge sys_d1cpre_clk);
        check_value("flags after clear", 32'(rst_flags), 32'(src_vec_t'(1 << SRC_PIN)));
        set_src(src_vec_t'(1 << SRC_PIN), 1'b0);
        wait_level(D1_BIT, 1'b1, 20, "d1 reset", n);

        // random single-cycle source pulses, power dips and clears
        for (int i = 0; i < 400; i++) begin
            @(posedge sys_d1cpre_clk);
            r = $urandom();
            rst_src    <= (r[3:0] == 4'd0) ? src_vec_t'(1) << (r[11:9] % 3'd6) : '0;
            dom_pwr_ok <= (r[8:4] == 5'd0) ? ~(dom_vec_t'(1) << (r[13:12] % 2'd3)) : '1;
            rmvf       <= (r[20:16] == 5'd0);
        end
        @(posedge sys_d1cpre_clk);
        rst_src    <= '0;
        dom_pwr_ok <= '1;
        rmvf       <= 1'b0;
        wait_level(D1_BIT, 1'b1, 40, "d1 reset", n);
        wait_level(D2_BIT, 1'b1, 40, "d2 reset", n);
        wait_level(PX_BIT, 1'b1, 40, "perx reset", n);

        $display("checks: %0d, errors: %0d, timeouts: %0d, assertion failures: %0d",
                 checks, errors, timeouts, u_rcc_rst_top.u_checker.fail_count);
        if (errors == 0 && timeouts == 0 && u_rcc_rst_top.u_checker.fail_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/rcc_rst_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module rcc_rst_checker (
    input logic                                 sys_d1cpre_clk,
    input logic                                 pwr_d1_ok,
    input rst_src_pkg::src_vec_t                src_sync,
    input rst_src_pkg::src_vec_t                rst_flags,
    input rst_domain_pkg::dom_vec_t             dom_rst_n,
    input rst_domain_pkg::dom_vec_t             released,
    input logic [2*rst_domain_pkg::NUM_DOM-1:0] dom_state
);

    import rst_domain_pkg::*;

    // number of failed assertions so far
    int fail_count = 0;

    for (genvar d = 0; d < NUM_DOM; d++) begin : gen_dom_chk
        // release only ever leaves the count state
        a_release_after_count: assert property (
            @(posedge sys_d1cpre_clk) disable iff (!pwr_d1_ok)
            $rose(dom_rst_n[d]) |-> $past(dom_state[2*d +: 2]) == ST_COUNT
        ) else begin
            $error("domain %0d reset rose without a count phase", d);
            fail_count++;
        end

        // one cycle wide
        a_release_pulse: assert property (
            @(posedge sys_d1cpre_clk) disable iff (!pwr_d1_ok)
            released[d] |=> !released[d]
        ) else begin
            $error("domain %0d release pulse longer than one cycle", d);
            fail_count++;
        end
    end

    // an active source keeps its flag through a clear
    a_flag_held: assert property (
        @(posedge sys_d1cpre_clk) disable iff (!pwr_d1_ok)
        |src_sync |=> (rst_flags & $past(src_sync)) == $past(src_sync)
    ) else begin
        $error("cause flag cleared while its source was active");
        fail_count++;
    end

endmodule

bind rcc_rst_top rcc_rst_checker u_checker (
    .sys_d1cpre_clk (sys_d1cpre_clk),
    .pwr_d1_ok      (pwr_d1_ok),
    .src_sync       (src_sync),
    .rst_flags      (rst_flags),
    .dom_rst_n      (dom_rst_n),
    .released       ({dom_if[2].released, dom_if[1].released, dom_if[0].released}),
    .dom_state      ({gen_dom[2].u_stretch.state,
                      gen_dom[1].u_stretch.state,
                      gen_dom[0].u_stretch.state})
);

`default_nettype wire

/* logic/rcc_rst_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rcc_rst_top (
    input  logic                     sys_d1cpre_clk,
    input  logic                     pwr_d1_ok,
    input  rst_src_pkg::src_vec_t    rst_src,
    input  rst_domain_pkg::dom_vec_t dom_pwr_ok,
    input  logic                     rmvf,
    output rst_domain_pkg::dom_vec_t dom_rst_n,
    output rst_src_pkg::src_vec_t    rst_flags,
    output logic                     nrst_out
);

    import rst_src_pkg::*;
    import rst_domain_pkg::*;

    // synchronized sources, shared with the flag unit
    src_vec_t src_sync;

    // one bundle per domain
    rst_domain_if dom_if [NUM_DOM] ();

    ////////////////////////////////////////
    // sync and request mapping
    ////////////////////////////////////////

    rst_source_sync u_source_sync (
        .sys_d1cpre_clk (sys_d1cpre_clk),
        .pwr_d1_ok      (pwr_d1_ok),
        .rst_src        (rst_src),
        .dom_pwr_ok     (dom_pwr_ok),
        .src_sync       (src_sync),
        .dom            (dom_if)
    );

    ////////////////////////////////////////
    // domain stretchers
    ////////////////////////////////////////

    for (genvar g = 0; g < NUM_DOM; g++) begin : gen_dom
        rst_domain_stretch #(
            .DURATION (DOM_DURATION[g])
        ) u_stretch (
            .sys_d1cpre_clk (sys_d1cpre_clk),
            .pwr_d1_ok      (pwr_d1_ok),
            .dom            (dom_if[g])
        );

        assign dom_rst_n[g] = dom_if[g].rst_n;
    end

    // flags and pin
    rst_flag_unit u_flags (
        .sys_d1cpre_clk (sys_d1cpre_clk),
        .pwr_d1_ok      (pwr_d1_ok),
        .src_sync       (src_sync),
        .rmvf           (rmvf),
        .rst_flags      (rst_flags),
        .nrst_out       (nrst_out),
        .dom            (dom_if)
    );

endmodule

`default_nettype wire

/* logic/rst_flag_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module rst_flag_unit (
    input  logic                  sys_d1cpre_clk,
    input  logic                  pwr_d1_ok,
    input  rst_src_pkg::src_vec_t src_sync,
    input  logic                  rmvf,
    output rst_src_pkg::src_vec_t rst_flags,
    output logic                  nrst_out,
    rst_domain_if.sink            dom [rst_domain_pkg::NUM_DOM]
);

    import rst_src_pkg::*;
    import rst_domain_pkg::*;

    logic pin_req;

    ////////////////////////////////////////
    // sticky cause flags
    ////////////////////////////////////////

    always_ff @(posedge sys_d1cpre_clk or negedge pwr_d1_ok) begin
        if (!pwr_d1_ok) begin
            rst_flags <= FLAG_RST_VAL;
        end else begin
            // set wins over the clear strobe
            rst_flags <= (rmvf ? src_vec_t'(0) : rst_flags) | src_sync;
        end
    end

    ////////////////////////////////////////
    // reset pin drive
    ////////////////////////////////////////

    // watchdogs and cpu software reset pull the pin directly
    assign pin_req = |(src_sync & PIN_DRIVE_MASK);

    always_ff @(posedge sys_d1cpre_clk or negedge pwr_d1_ok) begin
        if (!pwr_d1_ok) begin
            nrst_out <= 1'b0;
        end else if (pin_req) begin
            nrst_out <= 1'b0;
        end else if (dom[DOM_D1].released) begin
            // pin let go with the d1 release pulse
            nrst_out <= 1'b1;
        end else if (!dom[DOM_D1].rst_n) begin
            nrst_out <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* logic/rst_domain_stretch.sv */
`timescale 1ns/1ps
`default_nettype none

module rst_domain_stretch #(
    parameter rst_domain_pkg::cnt_t DURATION = 4'd10
) (
    input  logic          sys_d1cpre_clk,
    input  logic          pwr_d1_ok,
    rst_domain_if.stretch dom
);

    import rst_domain_pkg::*;

    stretch_state_e state;
    stretch_state_e state_nxt;
    cnt_t           cnt;
    cnt_t           cnt_nxt;
    cnt_t           cnt_step;
    logic           clean;
    logic           cnt_done;

    // no request and power good
    assign clean = !dom.req && dom.pwr_ok;

    // the hold exit edge counts as the first cycle
    assign cnt_step = (state == ST_HOLD) ? cnt_t'(1) : cnt + cnt_t'(1);
    assign cnt_done = (cnt_step == DURATION);

    ////////////////////////////////////////
    // next state
    ////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        cnt_nxt   = cnt;
        case (state)
            ST_HOLD: begin
                if (clean) begin
                    if (cnt_done) begin
                        // duration of one goes straight out
                        state_nxt = ST_RUN;
                    end else begin
                        state_nxt = ST_COUNT;
                        cnt_nxt   = cnt_step;
                    end
                end
            end
            ST_COUNT: begin
                if (!clean) begin
                    // re-request, count restarts later
                    state_nxt = ST_HOLD;
                    cnt_nxt   = '0;
                end else if (cnt_done) begin
                    state_nxt = ST_RUN;
                    cnt_nxt   = '0;
                end else begin
                    cnt_nxt = cnt_step;
                end
            end
            ST_RUN: begin
                if (!clean) begin
                    state_nxt = ST_HOLD;
                end
            end
            default: begin
                state_nxt = ST_HOLD;
                cnt_nxt   = '0;
            end
        endcase
    end

    ////////////////////////////////////////
    // state and outputs
    ////////////////////////////////////////

    always_ff @(posedge sys_d1cpre_clk or negedge pwr_d1_ok) begin
        if (!pwr_d1_ok) begin
            state        <= ST_HOLD;
            cnt          <= '0;
            dom.rst_n    <= 1'b0;
            dom.released <= 1'b0;
        end else begin
            state        <= state_nxt;
            cnt          <= cnt_nxt;
            // reset low everywhere but run
            dom.rst_n    <= (state_nxt == ST_RUN);
            // pulse on run entry only
            dom.released <= (state_nxt == ST_RUN) && (state != ST_RUN);
        end
    end

endmodule

`default_nettype wire

/* logic/rst_source_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module rst_source_sync (
    input  logic                     sys_d1cpre_clk,
    input  logic                     pwr_d1_ok,
    input  rst_src_pkg::src_vec_t    rst_src,
    input  rst_domain_pkg::dom_vec_t dom_pwr_ok,
    output rst_src_pkg::src_vec_t    src_sync,
    rst_domain_if.src                dom [rst_domain_pkg::NUM_DOM]
);

    import rst_src_pkg::*;
    import rst_domain_pkg::*;

    // synchronizer chains, stage 0 samples the async inputs
    src_vec_t src_pipe [SYNC_STAGES];
    dom_vec_t pwr_pipe [SYNC_STAGES];
    dom_vec_t pwr_sync;

    ////////////////////////////////////////
    // input synchronizers
    ////////////////////////////////////////

    always_ff @(posedge sys_d1cpre_clk or negedge pwr_d1_ok) begin
        if (!pwr_d1_ok) begin
            // sources quiet, power-good reads not ok
            for (int i = 0; i < SYNC_STAGES; i++) begin
                src_pipe[i] <= '0;
                pwr_pipe[i] <= '0;
            end
        end else begin
            src_pipe[0] <= rst_src;
            pwr_pipe[0] <= dom_pwr_ok;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                src_pipe[i] <= src_pipe[i-1];
                pwr_pipe[i] <= pwr_pipe[i-1];
            end
        end
    end

    // last stage, also feeds the flag unit
    assign src_sync = src_pipe[SYNC_STAGES-1];
    assign pwr_sync = pwr_pipe[SYNC_STAGES-1];

    ////////////////////////////////////////
    // per-domain request
    ////////////////////////////////////////

    for (genvar d = 0; d < NUM_DOM; d++) begin : gen_req
        // registered OR of masked sources, one cycle after sync
        always_ff @(posedge sys_d1cpre_clk or negedge pwr_d1_ok) begin
            if (!pwr_d1_ok) begin
                dom[d].req    <= 1'b0;
                dom[d].pwr_ok <= 1'b0;
            end else begin
                dom[d].req    <= |(src_sync & DOM_SRC_MASK[d]);
                dom[d].pwr_ok <= pwr_sync[d];
            end
        end
    end

endmodule

`default_nettype wire

/* logic/rst_domain_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface rst_domain_if;

    // synchronized request level and power-good
    logic req;
    logic pwr_ok;
    // active-low domain reset, and its one-cycle release pulse
    logic rst_n;
    logic released;

    // source side, after synchronization
    modport src (
        output req,
        output pwr_ok
    );

    // per-domain stretcher
    modport stretch (
        input  req,
        input  pwr_ok,
        output rst_n,
        output released
    );

    // flag unit only looks at the reset
    modport sink (
        input rst_n,
        input released
    );

endinterface

`default_nettype wire

/* logic/rst_domain_pkg.sv */
`default_nettype none

package rst_domain_pkg;

    import rst_src_pkg::*;

    // reset domains
    localparam int unsigned NUM_DOM  = 3;
    localparam int unsigned DOM_D1   = 0;
    localparam int unsigned DOM_D2   = 1;
    localparam int unsigned DOM_PERX = 2;

    // one bit per domain
    typedef logic [NUM_DOM-1:0] dom_vec_t;

    // release counter, covers durations up to 15
    typedef logic [3:0] cnt_t;

    // release delay per domain, in cycles
    localparam cnt_t DOM_DURATION [NUM_DOM] = '{4'd10, 4'd10, 4'd6};

    // which sources reset which domain
    // bit order: lpwr, cpu_sw, wwdg, iwdg, por_bor, pin
    // d1   : everything but lpwr
    // d2   : pin, por/bor, iwdg, lpwr
    // perx : same as d1
    localparam src_vec_t DOM_SRC_MASK [NUM_DOM] = '{
        6'b011111,
        6'b100111,
        6'b011111
    };

    // stretcher FSM
    typedef enum logic [1:0] {
        ST_HOLD,
        ST_COUNT,
        ST_RUN
    } stretch_state_e;

endpackage

`default_nettype wire

/* logic/rst_src_pkg.sv */
`default_nettype none

package rst_src_pkg;

    // number of reset sources
    localparam int unsigned NUM_SRC = 6;

    // source bit positions in a source vector
    localparam int unsigned SRC_PIN     = 0;
    localparam int unsigned SRC_POR_BOR = 1;
    localparam int unsigned SRC_IWDG    = 2;
    localparam int unsigned SRC_WWDG    = 3;
    localparam int unsigned SRC_CPU_SW  = 4;
    localparam int unsigned SRC_LPWR    = 5;

    // one bit per source, index order above
    typedef logic [NUM_SRC-1:0] src_vec_t;

    // flops in each synchronizer chain
    localparam int unsigned SYNC_STAGES = 2;

    // cause flags out of reset, only por/bor set
    localparam src_vec_t FLAG_RST_VAL = src_vec_t'(1) << SRC_POR_BOR;

    // internal sources that also pull the reset pin
    localparam src_vec_t PIN_DRIVE_MASK = (src_vec_t'(1) << SRC_IWDG)
                                        | (src_vec_t'(1) << SRC_WWDG)
                                        | (src_vec_t'(1) << SRC_CPU_SW);

endpackage

`default_nettype wire
